// ==== Bender.yml ====
package:
  name: ma_stage

sources:
  - logic/ma_pkg.sv
  - logic/csr_pkg.sv
  - logic/ma_wb_if.sv
  - logic/branch_unit.sv
  - logic/trap_csr_unit.sv
  - logic/pc_control.sv
  - logic/ma_wb_reg.sv
  - logic/load_decoder.sv
  - logic/ma_stage.sv
  - target: test
    files:
      - tests/tb_ma_stage.sv

// ==== logic/branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  logic           s_clk_i,
    input  logic           rst_n_i,
    input  ma_pkg::ictrl_t ictrl_i,  // Control of the MA instruction
    input  ma_pkg::funct_t f_i,      // Jump flag for BRU
    input  ma_pkg::word_t  val_i,    // Target with condition in bit 0
    output logic           taken_o,
    output ma_pkg::word_t  target_o
);

    logic is_bru;
    logic is_jump;
    logic cond_true;

    assign is_bru    = ictrl_i[ma_pkg::ICTRL_UNIT_BRU];
    assign is_jump   = f_i[ma_pkg::F_JUMP];
    assign cond_true = val_i[0]; // EX puts the compare result here

    // Jumps always leave, branches only with a true condition
    assign taken_o  = is_bru & (is_jump | cond_true);
    assign target_o = {val_i[31:1], 1'b0}; // Condition bit is not part of the address

    // The link result in WB needs a BRU instruction to belong to no other unit
    a_bru_single_unit : assert property (
        @(posedge s_clk_i) disable iff (!rst_n_i)
        is_bru |-> !(ictrl_i[ma_pkg::ICTRL_UNIT_ALU] || ictrl_i[ma_pkg::ICTRL_UNIT_LSU] ||
                     ictrl_i[ma_pkg::ICTRL_UNIT_CSR])
    );

endmodule

// ==== logic/csr_pkg.sv ====
package csr_pkg;

    typedef logic [11:0] csr_addr_t; // CSR address from the instruction payload

    // Machine-mode CSR addresses
    localparam csr_addr_t CSR_MSTATUS = 12'h300;
    localparam csr_addr_t CSR_MIE     = 12'h304;
    localparam csr_addr_t CSR_MTVEC   = 12'h305;
    localparam csr_addr_t CSR_MEPC    = 12'h341;
    localparam csr_addr_t CSR_MCAUSE  = 12'h342;

    // Field positions
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MIE_MTIE     = 7;  // Timer interrupt enable
    localparam int MIE_MEIE     = 11; // External interrupt enable

    // Trap causes, top bit marks an interrupt
    localparam logic [31:0] CAUSE_ILLEGAL = 32'h0000_0002;
    localparam logic [31:0] CAUSE_ECALL   = 32'h0000_000b;
    localparam logic [31:0] CAUSE_MTI     = 32'h8000_0007;
    localparam logic [31:0] CAUSE_MEI     = 32'h8000_000b;

    // CSR operation, low two bits of funct3
    localparam logic [1:0] CSR_RW = 2'b01;
    localparam logic [1:0] CSR_RS = 2'b10; // Set bits
    localparam logic [1:0] CSR_RC = 2'b11; // Clear bits

endpackage

// ==== logic/load_decoder.sv ====
`timescale 1ns/1ps

module load_decoder (
    ma_wb_if.reader          wb,
    output logic             wb_we_o,
    output ma_pkg::rf_addr_t wb_rd_o,
    output ma_pkg::word_t    wb_val_o
);

    ma_pkg::funct_t ld_f;
    logic [1:0]     ld_off;
    logic [7:0]     ld_byte;
    logic [15:0]    ld_half;
    ma_pkg::word_t  ld_val;

    assign ld_f    = wb.ldi[4:2];
    assign ld_off  = wb.ldi[1:0];                    // Byte offset in the bus word
    assign ld_byte = wb.val[{ld_off, 3'b000} +: 8];
    assign ld_half = ld_off[1] ? wb.val[31:16] : wb.val[15:0];

    always_comb begin
        case (ld_f)
            ma_pkg::LD_B:  ld_val = {{24{ld_byte[7]}}, ld_byte};
            ma_pkg::LD_BU: ld_val = {24'd0, ld_byte};
            ma_pkg::LD_H:  ld_val = {{16{ld_half[15]}}, ld_half};
            ma_pkg::LD_HU: ld_val = {16'd0, ld_half};
            ma_pkg::LD_W:  ld_val = wb.val;
            default:       ld_val = wb.val;
        endcase
    end

    // Non-load results pass through unchanged
    assign wb_val_o = wb.ictrl[ma_pkg::ICTRL_UNIT_LSU] ? ld_val : wb.val;
    assign wb_rd_o  = wb.rd;
    assign wb_we_o  = wb.ictrl[ma_pkg::ICTRL_REG_DEST];

endmodule

// ==== logic/ma_pkg.sv ====
package ma_pkg;

    // Pipeline data widths
    typedef logic [31:0] word_t;    // Data or address word
    typedef logic [4:0]  rf_addr_t; // Register file address
    typedef logic [7:0]  ictrl_t;   // Instruction control, all zero means no instruction
    typedef logic [2:0]  funct_t;   // Function field, meaning depends on the unit
    typedef logic [4:0]  ld_info_t; // Load function and the two low address bits

    // Bit positions inside ictrl_t
    localparam int ICTRL_REG_DEST = 0; // Result is written to the register file
    localparam int ICTRL_UNIT_ALU = 1;
    localparam int ICTRL_UNIT_LSU = 2; // Load or store
    localparam int ICTRL_UNIT_BRU = 3; // Branch or jump
    localparam int ICTRL_UNIT_CSR = 4;
    localparam int ICTRL_RVC      = 7; // Compressed, PC steps by 2

    // Set in the function field of a BRU instruction for jumps
    localparam int F_JUMP = 2;

    // Instruction misconduct reported by the decoder
    typedef enum logic [1:0] {
        FREE    = 2'b00, // Regular instruction
        ILLEGAL = 2'b01,
        ECALL   = 2'b10,
        MRET    = 2'b11  // Return from trap
    } imiscon_e;

    // Load function codes, same encoding as funct3
    localparam funct_t LD_B  = 3'b000;
    localparam funct_t LD_H  = 3'b001;
    localparam funct_t LD_W  = 3'b010;
    localparam funct_t LD_BU = 3'b100;
    localparam funct_t LD_HU = 3'b101;

endpackage

// ==== logic/ma_stage.sv ====
`timescale 1ns/1ps

module ma_stage #(
    parameter ma_pkg::word_t MTVEC_RESET = 32'h0000_0100 // Trap vector after reset
) (
    input  logic               s_clk_i,
    input  logic               rst_n_i,
    input  ma_pkg::word_t      boot_addr_i,
    input  logic               int_meip_i,
    input  logic               int_mtip_i,
    input  ma_pkg::word_t      lsu_data_i,
    input  logic               lsu_ready_i,   // Low extends the transfer
    input  ma_pkg::ictrl_t     ex_ictrl_i,
    input  ma_pkg::imiscon_e   ex_imiscon_i,
    input  ma_pkg::funct_t     ex_f_i,
    input  ma_pkg::rf_addr_t   ex_rd_i,
    input  ma_pkg::word_t      ex_val_i,
    input  csr_pkg::csr_addr_t ex_payload_i,  // CSR address
    output ma_pkg::word_t      pc_o,
    output logic               toc_o,
    output ma_pkg::word_t      toc_addr_o,
    output logic               stall_o,
    output logic               hold_o,
    output logic               wb_we_o,
    output ma_pkg::rf_addr_t   wb_rd_o,
    output ma_pkg::word_t      wb_val_o
);

    logic          bru_taken;
    ma_pkg::word_t bru_target;
    ma_pkg::word_t csr_rdata;
    logic          interrupt;
    logic          exception;
    logic          treturn;
    ma_pkg::word_t trap_addr;
    ma_pkg::word_t mepc;
    ma_pkg::word_t next_pc;
    logic          flush;

    ma_wb_if i_ma_wb ();

    branch_unit i_branch_unit (
        .s_clk_i (s_clk_i), .rst_n_i (rst_n_i), .ictrl_i (ex_ictrl_i), .f_i (ex_f_i),
        .val_i (ex_val_i), .taken_o (bru_taken), .target_o (bru_target)
    );

    trap_csr_unit #(.MTVEC_RESET(MTVEC_RESET)) i_trap_csr_unit (
        .s_clk_i (s_clk_i), .rst_n_i (rst_n_i), .ictrl_i (ex_ictrl_i),
        .imiscon_i (ex_imiscon_i), .f_i (ex_f_i), .payload_i (ex_payload_i),
        .val_i (ex_val_i), .pc_i (pc_o), .int_meip_i (int_meip_i), .int_mtip_i (int_mtip_i),
        .stall_i (stall_o), .flush_i (flush), .csr_rdata_o (csr_rdata),
        .interrupt_o (interrupt), .exception_o (exception), .treturn_o (treturn),
        .trap_addr_o (trap_addr), .mepc_o (mepc), .hold_o (hold_o)
    );

    pc_control i_pc_control (
        .s_clk_i (s_clk_i), .rst_n_i (rst_n_i), .boot_addr_i (boot_addr_i),
        .ictrl_i (ex_ictrl_i), .imiscon_i (ex_imiscon_i), .lsu_ready_i (lsu_ready_i),
        .taken_i (bru_taken), .target_i (bru_target), .interrupt_i (interrupt),
        .exception_i (exception), .treturn_i (treturn), .trap_addr_i (trap_addr),
        .mepc_i (mepc), .pc_o (pc_o), .next_pc_o (next_pc), .toc_o (toc_o),
        .toc_addr_o (toc_addr_o), .stall_o (stall_o), .flush_o (flush)
    );

    ma_wb_reg i_ma_wb_reg (
        .s_clk_i (s_clk_i), .rst_n_i (rst_n_i), .ictrl_i (ex_ictrl_i), .f_i (ex_f_i),
        .rd_i (ex_rd_i), .val_i (ex_val_i), .lsu_data_i (lsu_data_i), .next_pc_i (next_pc),
        .csr_rdata_i (csr_rdata), .stall_i (stall_o), .flush_i (flush), .wb (i_ma_wb.writer)
    );

    // WB slice, decodes loads straight from the pipeline register
    load_decoder i_load_decoder (
        .wb (i_ma_wb.reader), .wb_we_o (wb_we_o), .wb_rd_o (wb_rd_o), .wb_val_o (wb_val_o)
    );

endmodule

// ==== logic/ma_wb_if.sv ====
`timescale 1ns/1ps

// Contents of the MA/WB pipeline register
interface ma_wb_if;

    ma_pkg::ictrl_t   ictrl; // Zero for a bubble
    ma_pkg::rf_addr_t rd;    // Destination register
    ma_pkg::word_t    val;   // Raw result, undecoded for loads
    ma_pkg::ld_info_t ldi;   // Load width, sign and offset

    modport writer (
        output ictrl,
        output rd,
        output val,
        output ldi
    );

    modport reader (
        input ictrl,
        input rd,
        input val,
        input ldi
    );

endinterface

// ==== logic/ma_wb_reg.sv ====
`timescale 1ns/1ps

module ma_wb_reg (
    input  logic             s_clk_i,
    input  logic             rst_n_i,
    input  ma_pkg::ictrl_t   ictrl_i,
    input  ma_pkg::funct_t   f_i,
    input  ma_pkg::rf_addr_t rd_i,
    input  ma_pkg::word_t    val_i,        // EX result, address for loads
    input  ma_pkg::word_t    lsu_data_i,   // Raw bus word
    input  ma_pkg::word_t    next_pc_i,
    input  ma_pkg::word_t    csr_rdata_i,
    input  logic             stall_i,
    input  logic             flush_i,
    ma_wb_if.writer          wb
);

    ma_pkg::word_t result;
    logic          reg_en;

    // Only a real instruction that leaves MA this cycle updates the payload
    assign reg_en = (ictrl_i != '0) & ~flush_i & ~stall_i;

    always_comb begin
        if (ictrl_i[ma_pkg::ICTRL_UNIT_LSU]) begin
            result = lsu_data_i;   // Decoded later in WB
        end else if (ictrl_i[ma_pkg::ICTRL_UNIT_BRU]) begin
            result = next_pc_i;    // Link address
        end else if (ictrl_i[ma_pkg::ICTRL_UNIT_CSR]) begin
            result = csr_rdata_i;  // Old CSR value
        end else begin
            result = val_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            wb.ictrl <= '0;
        end else if (flush_i | stall_i) begin
            wb.ictrl <= '0; // Bubble into WB
        end else begin
            wb.ictrl <= ictrl_i;
        end
    end

    always_ff @(posedge s_clk_i) begin
        if (reg_en) begin
            wb.val <= result;
            wb.rd  <= rd_i;
            wb.ldi <= {f_i, val_i[1:0]};
        end
    end

    // A load in WB holds the word that the bus delivered with ready
    a_load_data_known : assert property (
        @(posedge s_clk_i) disable iff (!rst_n_i)
        (wb.ictrl[ma_pkg::ICTRL_UNIT_LSU] && wb.ictrl[ma_pkg::ICTRL_REG_DEST])
            |-> !$isunknown(wb.val)
    );

endmodule

// ==== logic/pc_control.sv ====
`timescale 1ns/1ps

module pc_control (
    input  logic             s_clk_i,
    input  logic             rst_n_i,
    input  ma_pkg::word_t    boot_addr_i,
    input  ma_pkg::ictrl_t   ictrl_i,
    input  ma_pkg::imiscon_e imiscon_i,
    input  logic             lsu_ready_i,
    input  logic             taken_i,      // From branch unit
    input  ma_pkg::word_t    target_i,
    input  logic             interrupt_i,
    input  logic             exception_i,
    input  logic             treturn_i,    // mret in MA
    input  ma_pkg::word_t    trap_addr_i,
    input  ma_pkg::word_t    mepc_i,
    output ma_pkg::word_t    pc_o,
    output ma_pkg::word_t    next_pc_o,    // Also the link address
    output logic             toc_o,
    output ma_pkg::word_t    toc_addr_o,
    output logic             stall_o,
    output logic             flush_o
);

    ma_pkg::word_t pc_q;
    ma_pkg::word_t new_pc;
    logic          ma_empty;
    logic          pc_load;

    assign ma_empty  = (ictrl_i == '0) && (imiscon_i == ma_pkg::FREE);
    assign stall_o   = ictrl_i[ma_pkg::ICTRL_UNIT_LSU] & ~lsu_ready_i; // Extended bus transfer
    assign flush_o   = interrupt_i | exception_i;
    assign next_pc_o = pc_q + (ictrl_i[ma_pkg::ICTRL_RVC] ? 32'd2 : 32'd4);

    // Traps first, then trap return, then taken branch
    always_comb begin
        if (interrupt_i | exception_i) begin
            new_pc = trap_addr_i;
        end else if (treturn_i) begin
            new_pc = mepc_i;
        end else if (taken_i) begin
            new_pc = target_i;
        end else begin
            new_pc = next_pc_o;
        end
    end

    assign toc_o      = interrupt_i | exception_i | treturn_i | taken_i;
    assign toc_addr_o = new_pc;
    assign pc_load    = (~ma_empty & ~stall_o) | flush_o; // Hold on bubbles and stalls

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            pc_q <= boot_addr_i;
        end else if (pc_load) begin
            pc_q <= new_pc;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== logic/trap_csr_unit.sv ====
`timescale 1ns/1ps

module trap_csr_unit #(
    parameter ma_pkg::word_t MTVEC_RESET = 32'h0000_0100
) (
    input  logic               s_clk_i,
    input  logic               rst_n_i,
    input  ma_pkg::ictrl_t     ictrl_i,
    input  ma_pkg::imiscon_e   imiscon_i,
    input  ma_pkg::funct_t     f_i,         // CSR operation
    input  csr_pkg::csr_addr_t payload_i,   // CSR address
    input  ma_pkg::word_t      val_i,       // CSR operand from EX
    input  ma_pkg::word_t      pc_i,
    input  logic               int_meip_i,  // External interrupt
    input  logic               int_mtip_i,  // Timer interrupt
    input  logic               stall_i,
    input  logic               flush_i,
    output ma_pkg::word_t      csr_rdata_o,
    output logic               interrupt_o,
    output logic               exception_o,
    output logic               treturn_o,
    output ma_pkg::word_t      trap_addr_o,
    output ma_pkg::word_t      mepc_o,
    output logic               hold_o
);

    logic          mstatus_mie;
    logic          mstatus_mpie;
    logic          mie_meie;
    logic          mie_mtie;
    ma_pkg::word_t mtvec;
    ma_pkg::word_t mepc;
    ma_pkg::word_t mcause;
    ma_pkg::word_t csr_wdata;
    ma_pkg::word_t trap_cause;
    logic          ma_empty;
    logic          int_ext;
    logic          int_pending;
    logic          csr_we;

    assign ma_empty    = (ictrl_i == '0) && (imiscon_i == ma_pkg::FREE);
    assign int_ext     = int_meip_i & mie_meie;
    assign int_pending = mstatus_mie & (int_ext | (int_mtip_i & mie_mtie));
    assign hold_o      = int_pending; // Keep EX from issuing while waiting

    // Wait for the data bus to finish before taking the interrupt
    assign interrupt_o = int_pending & ~ma_empty & ~ictrl_i[ma_pkg::ICTRL_UNIT_LSU];
    assign exception_o = ~interrupt_o & ((imiscon_i == ma_pkg::ILLEGAL) |
                                         (imiscon_i == ma_pkg::ECALL));
    assign treturn_o   = ~interrupt_o & (imiscon_i == ma_pkg::MRET);
    assign trap_addr_o = mtvec;  // Direct mode only
    assign mepc_o      = mepc;
    assign csr_we      = ictrl_i[ma_pkg::ICTRL_UNIT_CSR] & ~flush_i & ~stall_i;

    always_comb begin
        if (interrupt_o) begin
            trap_cause = int_ext ? csr_pkg::CAUSE_MEI : csr_pkg::CAUSE_MTI; // External first
        end else begin
            trap_cause = (imiscon_i == ma_pkg::ECALL) ? csr_pkg::CAUSE_ECALL
                                                      : csr_pkg::CAUSE_ILLEGAL;
        end
    end

    // Read port with MPP fixed to machine mode
    always_comb begin
        case (payload_i)
            csr_pkg::CSR_MSTATUS: csr_rdata_o = {19'd0, 2'b11, 3'd0, mstatus_mpie,
                                                 3'd0, mstatus_mie, 3'd0};
            csr_pkg::CSR_MIE:     csr_rdata_o = {20'd0, mie_meie, 3'd0, mie_mtie, 7'd0};
            csr_pkg::CSR_MTVEC:   csr_rdata_o = mtvec;
            csr_pkg::CSR_MEPC:    csr_rdata_o = mepc;
            csr_pkg::CSR_MCAUSE:  csr_rdata_o = mcause;
            default:              csr_rdata_o = '0;
        endcase
    end

    always_comb begin
        case (f_i[1:0])
            csr_pkg::CSR_RW: csr_wdata = val_i;
            csr_pkg::CSR_RS: csr_wdata = csr_rdata_o | val_i;
            csr_pkg::CSR_RC: csr_wdata = csr_rdata_o & ~val_i;
            default:         csr_wdata = val_i;
        endcase
    end

    always_ff @(posedge s_clk_i) begin
        if (!rst_n_i) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec        <= MTVEC_RESET;
        end else if (interrupt_o | exception_o) begin
            mstatus_mpie <= mstatus_mie; // Stack the enable, then mask
            mstatus_mie  <= 1'b0;
        end else if (treturn_o & ~stall_i) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (csr_we) begin
            case (payload_i)
                csr_pkg::CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[csr_pkg::MSTATUS_MIE];
                    mstatus_mpie <= csr_wdata[csr_pkg::MSTATUS_MPIE];
                end
                csr_pkg::CSR_MIE: begin
                    mie_meie <= csr_wdata[csr_pkg::MIE_MEIE];
                    mie_mtie <= csr_wdata[csr_pkg::MIE_MTIE];
                end
                csr_pkg::CSR_MTVEC: mtvec <= {csr_wdata[31:2], 2'b00};
                default: ;
            endcase
        end
    end

    // Trap record holds the PC of the instruction that did not complete
    always_ff @(posedge s_clk_i) begin
        if (interrupt_o | exception_o) begin
            mepc   <= pc_i;
            mcause <= trap_cause;
        end else if (csr_we && (payload_i == csr_pkg::CSR_MEPC)) begin
            mepc <= {csr_wdata[31:1], 1'b0};
        end else if (csr_we && (payload_i == csr_pkg::CSR_MCAUSE)) begin
            mcause <= csr_wdata;
        end
    end

    // CSR writes of a trapping instruction are dropped through the flush from PC control
    a_trap_flushes : assert property (
        @(posedge s_clk_i) disable iff (!rst_n_i)
        (interrupt_o || exception_o) |-> flush_i
    );

endmodule

// ==== src.f ====
logic/ma_pkg.sv
logic/csr_pkg.sv
logic/ma_wb_if.sv
logic/branch_unit.sv
logic/trap_csr_unit.sv
logic/pc_control.sv
logic/ma_wb_reg.sv
logic/load_decoder.sv
logic/ma_stage.sv
tests/tb_ma_stage.sv

// ==== tests/ma_trace.txt ====
// ictrl imiscon f rd val payload lsu_data ready meip mtip | toc toc_addr stall hold pc | we rd val
// Columns after mtip are expected outputs, the last three are WB of the previous line
03 0 0 01 12345678 000 00000000 1 0 0  0 00000000 0 0 00001000  0 00 00000000
83 0 0 02 0000cafe 000 00000000 1 0 0  0 00000000 0 0 00001004  1 01 12345678
11 0 2 03 00000008 300 00000000 1 0 0  0 00000000 0 0 00001006  1 02 0000cafe
11 0 2 04 00000000 300 00000000 1 0 0  0 00000000 0 0 0000100a  1 03 00001800
11 0 1 05 00000200 305 00000000 1 0 0  0 00000000 0 0 0000100e  1 04 00001808
05 0 0 06 00002001 000 11228344 1 0 0  0 00000000 0 0 00001012  1 05 00000100
05 0 5 07 00002002 000 87654321 0 0 0  0 00000000 1 0 00001016  1 06 ffffff83
05 0 5 07 00002002 000 87654321 1 0 0  0 00000000 0 0 00001016  0 00 00000000
05 0 0 08 00002003 000 7f000000 1 0 0  0 00000000 0 0 0000101a  1 07 00008765
05 0 5 09 00002000 000 0000f00d 1 0 0  0 00000000 0 0 0000101e  1 08 0000007f
05 0 0 0a 00002004 000 aaaaaa80 1 0 0  0 00000000 0 0 00001022  1 09 0000f00d
05 0 0 0b 00002006 000 00550000 1 0 0  0 00000000 0 0 00001026  1 0a ffffff80
09 0 4 01 00001100 000 00000000 1 0 0  1 00001100 0 0 0000102a  1 0b 00000055
08 0 0 00 00001200 000 00000000 1 0 0  0 00000000 0 0 00001100  1 01 0000102e
08 0 0 00 00001201 000 00000000 1 0 0  1 00001200 0 0 00001104  0 00 00000000
03 1 0 0c 00000099 000 00000000 1 0 0  1 00000200 0 0 00001200  0 00 00000000
11 0 2 0d 00000000 341 00000000 1 0 0  0 00000000 0 0 00000200  0 00 00000000
11 0 2 0e 00000000 342 00000000 1 0 0  0 00000000 0 0 00000204  1 0d 00001200
00 2 0 00 00000000 000 00000000 1 0 0  1 00000200 0 0 00000208  1 0e 00000002
11 0 2 0f 00000000 342 00000000 1 0 0  0 00000000 0 0 00000200  0 00 00000000
11 0 1 10 00000800 304 00000000 1 0 0  0 00000000 0 0 00000204  1 0f 0000000b
11 0 2 11 00000008 300 00000000 1 0 0  0 00000000 0 0 00000208  1 10 00000000
05 0 0 12 00003000 000 00000011 1 1 0  0 00000000 0 1 0000020c  1 11 00001800
03 0 0 13 00000005 000 00000000 1 1 0  1 00000200 0 1 00000210  1 12 00000011
11 0 2 14 00000000 342 00000000 1 1 0  0 00000000 0 0 00000200  0 00 00000000
00 3 0 00 00000000 000 00000000 1 0 0  1 00000210 0 0 00000204  1 14 8000000b
11 0 2 15 00000000 300 00000000 1 0 0  0 00000000 0 0 00000210  0 00 00000000
00 0 0 00 00000000 000 00000000 1 0 0  0 00000000 0 0 00000214  1 15 00001888

// ==== tests/tb_ma_stage.sv ====
`timescale 1ns/1ps

module tb_ma_stage;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int N_LINES      = 28;  // Cycles in the trace
    localparam int N_FIELDS     = 18;  // Values per trace line
    localparam int TIMEOUT_NS   = (N_LINES + RESET_CYCLES) * CLK_PERIOD * 2;

    logic                 s_clk;
    logic                 rst_n;
    ma_pkg::word_t        boot_addr;
    logic                 int_meip;
    logic                 int_mtip;
    ma_pkg::word_t        lsu_data;
    logic                 lsu_ready;
    ma_pkg::ictrl_t       ex_ictrl;
    ma_pkg::imiscon_e     ex_imiscon;
    ma_pkg::funct_t       ex_f;
    ma_pkg::rf_addr_t     ex_rd;
    ma_pkg::word_t        ex_val;
    csr_pkg::csr_addr_t   ex_payload;
    ma_pkg::word_t        pc;
    logic                 toc;
    ma_pkg::word_t        toc_addr;
    logic                 stall;
    logic                 hold;
    logic                 wb_we;
    ma_pkg::rf_addr_t     wb_rd;
    ma_pkg::word_t        wb_val;

    logic [31:0] trace_mem [0:N_LINES*N_FIELDS-1]; // Inputs then expected outputs per cycle
    int          check_count;
    int          mismatch_count;
    int          other_errors;

    ma_stage i_ma_stage (
        .s_clk_i      (s_clk),
        .rst_n_i      (rst_n),
        .boot_addr_i  (boot_addr),
        .int_meip_i   (int_meip),
        .int_mtip_i   (int_mtip),
        .lsu_data_i   (lsu_data),
        .lsu_ready_i  (lsu_ready),
        .ex_ictrl_i   (ex_ictrl),
        .ex_imiscon_i (ex_imiscon),
        .ex_f_i       (ex_f),
        .ex_rd_i      (ex_rd),
        .ex_val_i     (ex_val),
        .ex_payload_i (ex_payload),
        .pc_o         (pc),
        .toc_o        (toc),
        .toc_addr_o   (toc_addr),
        .stall_o      (stall),
        .hold_o       (hold),
        .wb_we_o      (wb_we),
        .wb_rd_o      (wb_rd),
        .wb_val_o     (wb_val)
    );

    always #(CLK_PERIOD/2) s_clk = ~s_clk;

    // Compare one output against its trace column
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        assert (actual === expected) else begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic apply_line(input int idx);
        int base;
        base       = idx * N_FIELDS;
        ex_ictrl   = trace_mem[base][7:0];
        ex_imiscon = ma_pkg::imiscon_e'(trace_mem[base+1][1:0]);
        ex_f       = trace_mem[base+2][2:0];
        ex_rd      = trace_mem[base+3][4:0];
        ex_val     = trace_mem[base+4];
        ex_payload = trace_mem[base+5][11:0];
        lsu_data   = trace_mem[base+6];
        lsu_ready  = trace_mem[base+7][0];
        int_meip   = trace_mem[base+8][0];
        int_mtip   = trace_mem[base+9][0];
    endtask

    task automatic check_line(input int idx);
        int base;
        base = idx * N_FIELDS + 10; // First expected column
        check_value("toc_o", toc, trace_mem[base]);
        if (trace_mem[base][0]) begin
            check_value("toc_addr_o", toc_addr, trace_mem[base+1]); // Only meaningful on a TOC
        end
        check_value("stall_o", stall, trace_mem[base+2]);
        check_value("hold_o", hold, trace_mem[base+3]);
        check_value("pc_o", pc, trace_mem[base+4]);
        check_value("wb_we_o", wb_we, trace_mem[base+5]);
        if (trace_mem[base+5][0]) begin
            check_value("wb_rd_o", wb_rd, trace_mem[base+6]);
            check_value("wb_val_o", wb_val, trace_mem[base+7]);
        end
    endtask

    initial begin
        s_clk          = 1'b0;
        rst_n          = 1'b0;
        boot_addr      = 32'h0000_1000;
        int_meip       = 1'b0;
        int_mtip       = 1'b0;
        lsu_data       = '0;
        lsu_ready      = 1'b1;
        ex_ictrl       = '0;
        ex_imiscon     = ma_pkg::FREE;
        ex_f           = '0;
        ex_rd          = '0;
        ex_val         = '0;
        ex_payload     = '0;
        check_count    = 0;
        mismatch_count = 0;
        other_errors   = 0;

        $readmemh("tests/ma_trace.txt", trace_mem);
        assert (!$isunknown(trace_mem[0]) && !$isunknown(trace_mem[N_LINES*N_FIELDS-1]))
        else begin
            $display("Trace file tests/ma_trace.txt is missing or has too few values");
            other_errors++;
        end

        repeat (RESET_CYCLES) @(posedge s_clk);

        for (int line_idx = 0; line_idx < N_LINES; line_idx++) begin
            @(negedge s_clk);
            rst_n = 1'b1;
            apply_line(line_idx);
            #(CLK_PERIOD/2 - 1); // Just before the capturing edge
            check_line(line_idx);
        end

        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Twice the expected run time
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the trace did not complete", TIMEOUT_NS);
        $display("Test FAILED");
        $finish;
    end

endmodule
